/* spm_pkg.sv */
package spm_pkg;

    // memory byte address and data word
    typedef logic [47:0] addr_t;
    typedef logic [63:0] word_t;

    // delta code: [1:0] kind, [6:2] delta, [7] unused
    typedef logic [7:0] code_t;

    // row or column index
    typedef logic [31:0] coord_t;

    // command word fields
    localparam int OPCODE_LSB    = 0;
    localparam int OPCODE_BITS   = 4;
    localparam int PE_LSB        = 4;
    localparam int PE_BITS       = 6;
    localparam int BROADCAST_BIT = 10;
    localparam int REG_LSB       = 11;
    localparam int REG_BITS      = 2;
    localparam int VALUE_LSB     = 16;
    localparam int VALUE_BITS    = 48;

    typedef enum logic [OPCODE_BITS-1:0] {
        OP_NOP    = 4'd0,
        OP_RST    = 4'd1,
        OP_LD     = 4'd2,
        OP_STEADY = 4'd3
    } op_code_t;

    // targets of OP_LD
    localparam logic [REG_BITS-1:0] REG_ADDR = 2'd0;
    localparam logic [REG_BITS-1:0] REG_END  = 2'd1;

    // kinds 2 and 3 are both padding
    typedef enum logic [1:0] {
        KIND_NEWLINE = 2'd0,
        KIND_STEP    = 2'd1,
        KIND_PAD     = 2'd2
    } code_kind_t;

    // address step per fetch
    localparam int WORD_BYTES = 8;

    typedef enum logic {
        IDLE   = 1'b0,
        STEADY = 1'b1
    } run_state_t;

endpackage

/* spm_control.sv */
`timescale 1ns/1ps

module spm_control #(
    parameter int PE_ID      = 0,
    parameter int FIFO_DEPTH = 16
) (
    input  logic           clk,
    input  logic           rst,
    input  spm_pkg::word_t op_in,
    input  logic           req_mem_stall,
    input  logic           rsp_mem_push,
    input  logic           word_taken,
    input  logic           pipe_empty,
    input  logic           fifo_empty,
    output logic           busy,
    output logic           req_mem_ld,
    output spm_pkg::addr_t req_mem_addr,
    output logic           decoder_clear
);
    import spm_pkg::*;

    localparam int CNT_BITS = $clog2(FIFO_DEPTH + 1);

    word_t               op_r;
    logic                req_mem_stall_r;
    run_state_t          state;
    run_state_t          next_state;
    addr_t               addr_q;
    addr_t               end_q;
    addr_t               next_addr;
    addr_t               next_end;
    logic [CNT_BITS-1:0] outstanding;
    logic                op_active;
    op_code_t            opcode;
    logic [REG_BITS-1:0] reg_sel;
    addr_t               op_value;
    logic                at_end;
    logic                quiet;
    logic                issue;

    // command fields of the registered op
    assign opcode    = op_code_t'(op_r[OPCODE_LSB +: OPCODE_BITS]);
    assign reg_sel   = op_r[REG_LSB +: REG_BITS];
    assign op_value  = op_r[VALUE_LSB +: VALUE_BITS];
    assign op_active = op_r[BROADCAST_BIT]
                    || (op_r[PE_LSB +: PE_BITS] == PE_BITS'(PE_ID));

    assign at_end = (addr_q == end_q);

    // nothing requested, buffered or in the pipeline
    assign quiet = (outstanding == '0) && fifo_empty && pipe_empty;

    // one fetch per cycle, bounded by the fifo space
    assign issue = (state == STEADY) && !at_end && !req_mem_stall_r
                && (outstanding < CNT_BITS'(FIFO_DEPTH));

    assign busy = (state == STEADY) || !quiet;

    always_comb begin
        next_state = state;
        next_addr  = addr_q;
        next_end   = end_q;
        if (issue) begin
            next_addr = addr_q + addr_t'(WORD_BYTES);
        end
        if (state == STEADY && at_end && quiet) begin
            next_state = IDLE;
        end
        // commands take priority over the run
        if (op_active) begin
            case (opcode)
                OP_RST: begin
                    next_state = IDLE;
                end
                OP_STEADY: begin
                    next_state = STEADY;
                end
                OP_LD: begin
                    if (reg_sel == REG_ADDR) begin
                        next_addr = op_value;
                    end else if (reg_sel == REG_END) begin
                        next_end = op_value;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            op_r            <= '0;
            req_mem_stall_r <= 1'b0;
            state           <= IDLE;
            addr_q          <= '0;
            end_q           <= '0;
            outstanding     <= '0;
            req_mem_ld      <= 1'b0;
            decoder_clear   <= 1'b0;
        end else begin
            op_r            <= op_in;
            req_mem_stall_r <= req_mem_stall;
            state           <= next_state;
            addr_q          <= next_addr;
            end_q           <= next_end;
            req_mem_ld      <= issue;
            decoder_clear   <= op_active && (opcode == OP_RST);
            // words requested but not yet taken by the unpacker
            case ({issue, word_taken})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    // address travels with the strobe
    always_ff @(posedge clk) begin
        req_mem_addr <= addr_q;
    end

endmodule

/* spm_response_fifo.sv */
`timescale 1ns/1ps

module spm_response_fifo #(
    parameter int DEPTH = 16
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           rsp_mem_push,
    input  spm_pkg::word_t rsp_mem_q,
    input  logic           fifo_pop,
    output spm_pkg::word_t fifo_q,
    output logic           fifo_empty,
    output logic           rsp_mem_stall
);
    import spm_pkg::*;

    localparam int PTR_BITS = $clog2(DEPTH);
    localparam int CNT_BITS = $clog2(DEPTH + 1);
    // free entries left when the stall rises
    localparam int AF_FREE  = 4;

    word_t               mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                pop;

    // first word falls through
    assign fifo_q     = mem[rd_ptr];
    assign fifo_empty = (count == '0);
    assign pop        = fifo_pop && !fifo_empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            rsp_mem_stall <= 1'b0;
        end else begin
            if (rsp_mem_push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_BITS'(rsp_mem_push) - CNT_BITS'(pop);
            rsp_mem_stall <= (count >= CNT_BITS'(DEPTH - AF_FREE));
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_mem_push) begin
            mem[wr_ptr] <= rsp_mem_q;
        end
    end

endmodule

/* spm_code_unpacker.sv */
`timescale 1ns/1ps

module spm_code_unpacker (
    input  logic           clk,
    input  logic           rst,
    input  logic           decoder_clear,
    input  spm_pkg::word_t fifo_q,
    input  logic           fifo_empty,
    input  logic           stall_index,
    output logic           fifo_pop,
    output logic           word_taken,
    output logic           code_valid,
    output spm_pkg::code_t code
);
    import spm_pkg::*;

    word_t      hold_word;
    logic       hold_valid;
    logic [2:0] byte_idx;
    logic       last_byte;

    // least significant byte first
    assign code       = hold_word[{byte_idx, 3'b000} +: 8];
    assign code_valid = hold_valid && !stall_index;
    assign last_byte  = (byte_idx == 3'd7);

    // the word leaves the fifo once its eighth byte is out,
    // so the fifo and the count keep covering it until then
    assign fifo_pop   = hold_valid && (decoder_clear || (code_valid && last_byte));
    assign word_taken = fifo_pop;

    always_ff @(posedge clk) begin
        if (rst || decoder_clear) begin
            hold_valid <= 1'b0;
            byte_idx   <= '0;
        end else if (!hold_valid) begin
            if (!fifo_empty) begin
                hold_valid <= 1'b1;
            end
            byte_idx <= '0;
        end else if (code_valid) begin
            byte_idx <= byte_idx + 1'b1;
            if (last_byte) begin
                hold_valid <= 1'b0;
            end
        end
    end

    // copy of the fifo head
    always_ff @(posedge clk) begin
        if (!hold_valid && !fifo_empty) begin
            hold_word <= fifo_q;
        end
    end

endmodule

/* spm_coord_pipeline.sv */
`timescale 1ns/1ps

module spm_coord_pipeline #(
    parameter int LOG2_SUB_WIDTH  = 2,
    parameter int LOG2_SUB_HEIGHT = 2
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            decoder_clear,
    input  logic            code_valid,
    input  spm_pkg::code_t  code,
    output logic            push_index,
    output spm_pkg::coord_t row,
    output spm_pkg::coord_t col,
    output logic            pipe_empty
);
    import spm_pkg::*;

    localparam int LOW_BITS = LOG2_SUB_WIDTH + LOG2_SUB_HEIGHT;
    localparam int COL_HI   = 32 - LOG2_SUB_WIDTH;
    localparam int ROW_HI   = 32 - LOG2_SUB_HEIGHT;

    // stage 1
    logic       s1_valid;
    code_kind_t s1_kind;
    logic [5:0] s1_step;

    // stage 2
    logic   s2_push;
    coord_t row_q;
    coord_t col_q;

    coord_t                   step_ext;
    logic [LOG2_SUB_WIDTH:0]  col_lo;
    logic [LOG2_SUB_HEIGHT:0] row_lo;
    logic [COL_HI-1:0]        col_hi;
    logic [ROW_HI-1:0]        row_hi;

    assign pipe_empty = !(s1_valid || s2_push || push_index);

    always_ff @(posedge clk) begin
        s1_kind <= code_kind_t'(code[1:0]);
        s1_step <= {1'b0, code[6:2]} + 6'd1;
    end

    // tiled add, carries ripple col low -> row low -> col high
    always_comb begin
        step_ext = coord_t'(s1_step);
        col_lo = {1'b0, col_q[LOG2_SUB_WIDTH-1:0]} + {1'b0, step_ext[LOG2_SUB_WIDTH-1:0]};
        row_lo = {1'b0, row_q[LOG2_SUB_HEIGHT-1:0]}
               + {1'b0, step_ext[LOW_BITS-1:LOG2_SUB_WIDTH]}
               + (LOG2_SUB_HEIGHT + 1)'(col_lo[LOG2_SUB_WIDTH]);
        col_hi = col_q[31:LOG2_SUB_WIDTH] + COL_HI'(step_ext[31:LOW_BITS])
               + COL_HI'(row_lo[LOG2_SUB_HEIGHT]);
        row_hi = row_q[31:LOG2_SUB_HEIGHT];
        if (s1_kind == KIND_NEWLINE) begin
            col_lo = '1;
            row_lo = '1;
            col_hi = '1;
            row_hi = row_q[31:LOG2_SUB_HEIGHT] + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || decoder_clear) begin
            s1_valid   <= 1'b0;
            s2_push    <= 1'b0;
            push_index <= 1'b0;
            row_q      <= '0;
            row_q[LOG2_SUB_HEIGHT-1:0] <= '1;
            col_q      <= '1;
        end else begin
            s1_valid   <= code_valid;
            s2_push    <= s1_valid && (s1_kind == KIND_STEP);
            push_index <= s2_push;
            // padding leaves the coordinates alone
            if (s1_valid && (s1_kind == KIND_STEP || s1_kind == KIND_NEWLINE)) begin
                row_q <= {row_hi, row_lo[LOG2_SUB_HEIGHT-1:0]};
                col_q <= {col_hi, col_lo[LOG2_SUB_WIDTH-1:0]};
            end
        end
    end

    // stage 3
    always_ff @(posedge clk) begin
        row <= row_q;
        col <= col_q;
    end

endmodule

/* spm_decoder_top.sv */
`timescale 1ns/1ps

module spm_decoder_top #(
    parameter int PE_ID           = 0,
    parameter int FIFO_DEPTH      = 16,
    parameter int LOG2_SUB_WIDTH  = 2,
    parameter int LOG2_SUB_HEIGHT = 2
) (
    input  logic            clk,
    input  logic            rst,
    input  spm_pkg::word_t  op_in,
    output logic            busy,
    output logic            req_mem_ld,
    output spm_pkg::addr_t  req_mem_addr,
    input  logic            req_mem_stall,
    input  logic            rsp_mem_push,
    input  spm_pkg::word_t  rsp_mem_q,
    output logic            rsp_mem_stall,
    output logic            push_index,
    output spm_pkg::coord_t row,
    output spm_pkg::coord_t col,
    input  logic            stall_index
);
    import spm_pkg::*;

    word_t fifo_q;
    logic  fifo_empty;
    logic  fifo_pop;
    logic  word_taken;
    logic  code_valid;
    code_t code;
    logic  decoder_clear;
    logic  pipe_empty;

    spm_control #(
        .PE_ID      (PE_ID),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_control (
        .clk           (clk),
        .rst           (rst),
        .op_in         (op_in),
        .req_mem_stall (req_mem_stall),
        .rsp_mem_push  (rsp_mem_push),
        .word_taken    (word_taken),
        .pipe_empty    (pipe_empty),
        .fifo_empty    (fifo_empty),
        .busy          (busy),
        .req_mem_ld    (req_mem_ld),
        .req_mem_addr  (req_mem_addr),
        .decoder_clear (decoder_clear)
    );

    spm_response_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) i_fifo (
        .clk           (clk),
        .rst           (rst),
        .rsp_mem_push  (rsp_mem_push),
        .rsp_mem_q     (rsp_mem_q),
        .fifo_pop      (fifo_pop),
        .fifo_q        (fifo_q),
        .fifo_empty    (fifo_empty),
        .rsp_mem_stall (rsp_mem_stall)
    );

    spm_code_unpacker i_unpacker (
        .clk           (clk),
        .rst           (rst),
        .decoder_clear (decoder_clear),
        .fifo_q        (fifo_q),
        .fifo_empty    (fifo_empty),
        .stall_index   (stall_index),
        .fifo_pop      (fifo_pop),
        .word_taken    (word_taken),
        .code_valid    (code_valid),
        .code          (code)
    );

    spm_coord_pipeline #(
        .LOG2_SUB_WIDTH  (LOG2_SUB_WIDTH),
        .LOG2_SUB_HEIGHT (LOG2_SUB_HEIGHT)
    ) i_pipeline (
        .clk           (clk),
        .rst           (rst),
        .decoder_clear (decoder_clear),
        .code_valid    (code_valid),
        .code          (code),
        .push_index    (push_index),
        .row           (row),
        .col           (col),
        .pipe_empty    (pipe_empty)
    );

endmodule

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk = ~clk;
        end
    end

endmodule

/* tb_spm_decoder.sv */
`timescale 1ns/1ps

module tb_spm_decoder;
    import spm_pkg::*;

    // same values as the top level defaults
    localparam int PE_ID           = 0;
    localparam int FIFO_DEPTH      = 16;
    localparam int LOG2_SUB_WIDTH  = 2;
    localparam int LOG2_SUB_HEIGHT = 2;

    localparam int    OTHER_PE    = PE_ID + 5;
    localparam int    IMG_WORDS   = 200;
    localparam addr_t IMG_BASE    = 48'h0012_3400_0000;
    localparam int    ABORT_FIRST = 130;
    localparam int    ABORT_RAND  = 6;
    localparam int    ABORT_WORDS = 30;

    localparam coord_t COL_LO_MASK = coord_t'((1 << LOG2_SUB_WIDTH) - 1);
    localparam coord_t ROW_LO_MASK = coord_t'((1 << LOG2_SUB_HEIGHT) - 1);

    logic   clk;
    logic   rst;
    word_t  op_in;
    logic   busy;
    logic   req_mem_ld;
    addr_t  req_mem_addr;
    logic   req_mem_stall;
    logic   rsp_mem_push;
    word_t  rsp_mem_q;
    logic   rsp_mem_stall;
    logic   push_index;
    coord_t row;
    coord_t col;
    logic   stall_index;

    logic [31:0] rng_state = 32'd71;
    word_t       image [IMG_WORDS];
    word_t       cmd_q [$];
    addr_t       exp_req [$];
    coord_t      exp_row [$];
    coord_t      exp_col [$];
    word_t       rsp_data [$];
    int          rsp_ready [$];
    int          cycle = 0;
    logic        random_stall = 1'b0;
    coord_t      model_row;
    coord_t      model_col;

    tb_clock #(.PERIOD_NS(8)) i_clock (.clk(clk));

    spm_decoder_top #(
        .PE_ID           (PE_ID),
        .FIFO_DEPTH      (FIFO_DEPTH),
        .LOG2_SUB_WIDTH  (LOG2_SUB_WIDTH),
        .LOG2_SUB_HEIGHT (LOG2_SUB_HEIGHT)
    ) i_dut (
        .clk           (clk),
        .rst           (rst),
        .op_in         (op_in),
        .busy          (busy),
        .req_mem_ld    (req_mem_ld),
        .req_mem_addr  (req_mem_addr),
        .req_mem_stall (req_mem_stall),
        .rsp_mem_push  (rsp_mem_push),
        .rsp_mem_q     (rsp_mem_q),
        .rsp_mem_stall (rsp_mem_stall),
        .push_index    (push_index),
        .row           (row),
        .col           (col),
        .stall_index   (stall_index)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic code_t step_code(input logic [31:0] r);
        return {r[16], r[12:8], KIND_STEP};
    endfunction

    // kinds 2 and 3 both pad
    function automatic code_t pad_code(input logic [31:0] r);
        return {r[16], r[12:8], 1'b1, r[4]};
    endfunction

    function automatic code_t random_code();
        logic [31:0] r;
        r = next_rand();
        if (r[3:0] < 4'd10) begin
            return step_code(r);
        end else if (r[3:0] < 4'd13) begin
            return {r[16], r[12:8], KIND_NEWLINE};
        end else begin
            return pad_code(r);
        end
    endfunction

    function automatic word_t make_cmd(input op_code_t op, input int pe, input logic bcast,
                                       input logic [REG_BITS-1:0] sel, input addr_t value);
        word_t w;
        w = '0;
        w[OPCODE_LSB +: OPCODE_BITS] = op;
        w[PE_LSB +: PE_BITS]         = PE_BITS'(pe);
        w[BROADCAST_BIT]             = bcast;
        w[REG_LSB +: REG_BITS]       = sel;
        w[VALUE_LSB +: VALUE_BITS]   = value;
        return w;
    endfunction

    function automatic addr_t word_addr(input int idx);
        return IMG_BASE + addr_t'(idx * WORD_BYTES);
    endfunction

    task automatic fill_image();
        for (int i = 0; i < IMG_WORDS; i++) begin
            for (int b = 0; b < 8; b++) begin
                image[i][8*b +: 8] = random_code();
            end
        end
        // abort region ends its random part on a step, then pads only
        image[ABORT_FIRST + ABORT_RAND - 1][63:56] = step_code(next_rand());
        for (int i = ABORT_FIRST + ABORT_RAND; i < ABORT_FIRST + ABORT_WORDS; i++) begin
            for (int b = 0; b < 8; b++) begin
                image[i][8*b +: 8] = pad_code(next_rand());
            end
        end
    endtask

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("** Error at time %0t: %s is %h, expected %h",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_coord(input string name, input coord_t got, input coord_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("** Error at time %0t: %s is %0d, expected %0d",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("** Error at time %0t: %s is %b, expected %b",
                                        $time, name, got, exp));
        end
    endtask

    // reset values: row low bits all ones, col all ones
    task automatic model_reset();
        model_row = ROW_LO_MASK;
        model_col = '1;
    endtask

    // tiled add: col low, then row low, then col high, carries ripple up
    task automatic apply_step(input logic [5:0] step);
        logic [63:0] col_low;
        logic [63:0] row_low;
        logic [63:0] col_high;
        coord_t      s;
        s        = coord_t'(step);
        col_low  = 64'(model_col & COL_LO_MASK) + 64'(s & COL_LO_MASK);
        row_low  = 64'(model_row & ROW_LO_MASK) + 64'((s >> LOG2_SUB_WIDTH) & ROW_LO_MASK)
                 + (col_low >> LOG2_SUB_WIDTH);
        col_high = 64'(model_col >> LOG2_SUB_WIDTH)
                 + 64'(s >> (LOG2_SUB_WIDTH + LOG2_SUB_HEIGHT))
                 + (row_low >> LOG2_SUB_HEIGHT);
        model_col = coord_t'((col_high << LOG2_SUB_WIDTH) | (col_low & 64'(COL_LO_MASK)));
        model_row = (model_row & ~ROW_LO_MASK) | coord_t'(row_low & 64'(ROW_LO_MASK));
    endtask

    task automatic apply_newline();
        model_col = '1;
        model_row = (((model_row >> LOG2_SUB_HEIGHT) + 1) << LOG2_SUB_HEIGHT) | ROW_LO_MASK;
    endtask

    task automatic expect_requests(input int first, input int n);
        for (int w = first; w < first + n; w++) begin
            exp_req.push_back(word_addr(w));
        end
    endtask

    // bytes go out least significant first
    task automatic expect_codes(input int first, input int n);
        code_t c;
        for (int w = first; w < first + n; w++) begin
            for (int b = 0; b < 8; b++) begin
                c = image[w][8*b +: 8];
                if (c[1:0] == KIND_STEP) begin
                    apply_step({1'b0, c[6:2]} + 6'd1);
                    exp_row.push_back(model_row);
                    exp_col.push_back(model_col);
                end else if (c[1:0] == KIND_NEWLINE) begin
                    apply_newline();
                end
            end
        end
    endtask

    task automatic send_cmd(input word_t cmd);
        int n;
        n = 0;
        cmd_q.push_back(cmd);
        @(negedge clk);
        while (cmd_q.size() != 0) begin
            n++;
            if (n > 10) begin
                stop_with_failure("command was never driven onto op_in");
            end else begin
                @(negedge clk);
            end
        end
    endtask

    task automatic load_region(input int first, input int n, input int pe);
        send_cmd(make_cmd(OP_LD, pe, 1'b0, REG_ADDR, word_addr(first)));
        send_cmd(make_cmd(OP_LD, pe, 1'b0, REG_END, word_addr(first + n)));
    endtask

    task automatic wait_busy(input logic level, input int max_cycles, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (busy !== level) begin
            n++;
            if (n > max_cycles) begin
                stop_with_failure($sformatf("timeout waiting for busy to become %b in %s",
                                            level, what));
            end else begin
                @(negedge clk);
            end
        end
    endtask

    task automatic wait_pushes_done(input int max_cycles);
        int n;
        n = 0;
        while (exp_row.size() != 0) begin
            n++;
            if (n > max_cycles) begin
                stop_with_failure("timeout waiting for the expected coordinates");
            end else begin
                @(negedge clk);
            end
        end
    endtask

    task automatic finish_run(input string what);
        wait_busy(1'b1, 20, what);
        wait_busy(1'b0, 50000, what);
        @(negedge clk);
        if (exp_req.size() != 0) begin
            stop_with_failure($sformatf("%0d memory requests missing after %s",
                                        exp_req.size(), what));
        end else if (exp_row.size() != 0) begin
            stop_with_failure($sformatf("%0d coordinates missing after %s",
                                        exp_row.size(), what));
        end
    endtask

    task automatic run_region(input int first, input int n, input string what);
        expect_requests(first, n);
        expect_codes(first, n);
        load_region(first, n, PE_ID);
        send_cmd(make_cmd(OP_STEADY, PE_ID, 1'b0, REG_ADDR, '0));
        finish_run(what);
    endtask

    // inputs change 1 ns after the rising edge
    initial begin
        op_in         = '0;
        req_mem_stall = 1'b0;
        rsp_mem_push  = 1'b0;
        rsp_mem_q     = '0;
        stall_index   = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            cycle++;
            if (cmd_q.size() != 0) begin
                op_in = cmd_q.pop_front();
            end else begin
                op_in = '0;
            end
            req_mem_stall = (next_rand() % 4) == 0;
            stall_index   = random_stall && ((next_rand() % 3) == 0);
            rsp_mem_push  = 1'b0;
            // in-order responses, held back while the fifo is almost full
            if (rsp_data.size() != 0 && !rsp_mem_stall) begin
                if (rsp_ready[0] <= cycle && (next_rand() % 4) != 0) begin
                    rsp_mem_q = rsp_data.pop_front();
                    void'(rsp_ready.pop_front());
                    rsp_mem_push = 1'b1;
                end
            end
        end
    end

    // outputs sampled on the falling edge
    initial begin
        addr_t offset;
        forever begin
            @(negedge clk);
            if (req_mem_ld === 1'b1) begin
                offset = req_mem_addr - IMG_BASE;
                if (exp_req.size() == 0) begin
                    stop_with_failure($sformatf("unexpected memory request to address %h",
                                                req_mem_addr));
                end else begin
                    check_addr("req_mem_addr", req_mem_addr, exp_req.pop_front());
                end
                rsp_data.push_back(image[offset / WORD_BYTES]);
                rsp_ready.push_back(cycle + 1 + int'(next_rand() % 4));
            end
            if (push_index === 1'b1) begin
                if (exp_row.size() == 0) begin
                    stop_with_failure("push_index high with no coordinate expected");
                end else begin
                    check_coord("row", row, exp_row.pop_front());
                    check_coord("col", col, exp_col.pop_front());
                end
            end
        end
    end

    initial begin
        fill_image();
        model_reset();
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_flag("busy", busy, 1'b0);
        check_flag("req_mem_ld", req_mem_ld, 1'b0);
        check_flag("rsp_mem_stall", rsp_mem_stall, 1'b0);
        check_flag("push_index", push_index, 1'b0);

        run_region(0, 40, "the first run");
        random_stall = 1'b1;
        run_region(40, 60, "the run under stall_index");

        // foreign PE without broadcast must be ignored
        load_region(100, 30, PE_ID);
        send_cmd(make_cmd(OP_LD, OTHER_PE, 1'b0, REG_END, word_addr(101)));
        send_cmd(make_cmd(OP_STEADY, OTHER_PE, 1'b0, REG_ADDR, '0));
        repeat (30) begin
            @(negedge clk);
            check_flag("busy", busy, 1'b0);
        end
        expect_requests(100, 30);
        expect_codes(100, 30);
        send_cmd(make_cmd(OP_STEADY, OTHER_PE, 1'b1, REG_ADDR, '0));
        finish_run("the broadcast run");

        // clear in the middle of a run, only padding words left behind
        expect_requests(ABORT_FIRST, ABORT_WORDS);
        expect_codes(ABORT_FIRST, ABORT_RAND);
        load_region(ABORT_FIRST, ABORT_WORDS, PE_ID);
        send_cmd(make_cmd(OP_STEADY, PE_ID, 1'b0, REG_ADDR, '0));
        wait_busy(1'b1, 20, "the aborted run");
        wait_pushes_done(50000);
        send_cmd(make_cmd(OP_RST, PE_ID, 1'b0, REG_ADDR, '0));
        model_reset();
        wait_busy(1'b0, 50000, "the drain after the clear");
        @(negedge clk);
        exp_req.delete();
        run_region(160, 40, "the run after the clear");

        if (exp_req.size() != 0 || exp_row.size() != 0) begin
            stop_with_failure("expected requests or coordinates left over at the end");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

/* sparse_index_decoder.f */
spm_pkg.sv
spm_control.sv
spm_response_fifo.sv
spm_code_unpacker.sv
spm_coord_pipeline.sv
spm_decoder_top.sv
tb_clock.sv
tb_spm_decoder.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_spm_decoder -f sparse_index_decoder.f
./obj_dir/Vtb_spm_decoder
